// ==== hw/banked_lane_mem.sv ====
module banked_lane_mem #(
    parameter int READ_LATENCY = 9,                // per-bank pipeline depth.
    parameter int BANK_LANES   = 256,              // lanes in each bank.
    parameter int ORDER_DEPTH  = 8                 // outstanding read limit.
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  mem_txn_pkg::mem_op_e req_op_i,
    input  mem_geom_pkg::addr_t  req_addr_i,
    input  mem_geom_pkg::lane_t  req_wdata_i,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output mem_geom_pkg::lane_t  rsp_rdata_o
);

    // --------------------
    // channels
    // --------------------

    mem_req_if up_req ();                          // from the cache side.
    mem_rsp_if up_rsp ();                          // back to the cache side.
    mem_req_if bank_req [mem_txn_pkg::NUM_BANKS] ();
    mem_rsp_if bank_rsp [mem_txn_pkg::NUM_BANKS] ();

    assign up_req.valid = req_valid_i;
    assign up_req.op    = req_op_i;
    assign up_req.addr  = req_addr_i;
    assign up_req.wdata = req_wdata_i;
    assign req_ready_o  = up_req.ready;

    assign rsp_valid_o  = up_rsp.valid;
    assign rsp_rdata_o  = up_rsp.rdata;
    assign up_rsp.ready = rsp_ready_i;

    // --------------------
    // router and banks
    // --------------------

    lane_order_ctrl #(
        .ORDER_DEPTH (ORDER_DEPTH)
    ) u_order (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .up_req   (up_req),
        .up_rsp   (up_rsp),
        .bank_req (bank_req),
        .bank_rsp (bank_rsp)
    );

    for (genvar b = 0; b < mem_txn_pkg::NUM_BANKS; b++) begin : g_bank
        mem_bank #(
            .READ_LATENCY (READ_LATENCY),
            .BANK_LANES   (BANK_LANES)
        ) u_bank (
            .clk_i (clk_i),
            .rst_i (rst_i),
            .req   (bank_req[b]),
            .rsp   (bank_rsp[b])
        );
    end

endmodule

// ==== hw/lane_order_ctrl.sv ====
module lane_order_ctrl #(
    parameter int ORDER_DEPTH = 8                  // reads allowed in flight.
) (
    input logic       clk_i,
    input logic       rst_i,
    mem_req_if.slave  up_req,
    mem_rsp_if.source up_rsp,
    mem_req_if.master bank_req [mem_txn_pkg::NUM_BANKS],
    mem_rsp_if.sink   bank_rsp [mem_txn_pkg::NUM_BANKS]
);

    localparam int PTR_BITS = $clog2(ORDER_DEPTH);

    // --------------------
    // order queue state
    // --------------------

    mem_txn_pkg::bank_id_t order_q [ORDER_DEPTH];  // bank of each read in issue order.
    logic [PTR_BITS-1:0]   wr_ptr;                 // next free slot.
    logic [PTR_BITS-1:0]   rd_ptr;                 // oldest read.
    logic [PTR_BITS:0]     count;                  // reads outstanding.

    mem_txn_pkg::bank_id_t req_bank;               // target of the offered request.
    mem_txn_pkg::bank_id_t head_bank;              // bank owed the next response.
    logic                  q_full;
    logic                  q_empty;
    logic                  is_read;
    logic                  can_issue;              // queue has room or not a read.
    logic                  push;
    logic                  pop;

    logic                  bank_ready [mem_txn_pkg::NUM_BANKS];
    logic                  bank_vld   [mem_txn_pkg::NUM_BANKS];
    mem_geom_pkg::lane_t   bank_rdata [mem_txn_pkg::NUM_BANKS];

    assign req_bank  = mem_txn_pkg::bank_id_t'(up_req.addr[mem_geom_pkg::BANK_SEL_BIT]);
    assign head_bank = order_q[rd_ptr];
    assign q_full    = (count == (PTR_BITS+1)'(ORDER_DEPTH));
    assign q_empty   = (count == '0);
    assign is_read   = (up_req.op == mem_txn_pkg::MEM_OP_READ);
    assign can_issue = !(is_read && q_full);

    // --------------------
    // bank steering
    // --------------------

    for (genvar b = 0; b < mem_txn_pkg::NUM_BANKS; b++) begin : g_bank
        // request goes only to the addressed bank.
        assign bank_req[b].valid = up_req.valid && can_issue &&
                                   (req_bank == mem_txn_pkg::bank_id_t'(b));
        assign bank_req[b].op    = up_req.op;      // payload fans out to both.
        assign bank_req[b].addr  = up_req.addr;
        assign bank_req[b].wdata = up_req.wdata;
        assign bank_ready[b]     = bank_req[b].ready;

        assign bank_vld[b]   = bank_rsp[b].valid;
        assign bank_rdata[b] = bank_rsp[b].rdata;
        // other bank stays stalled until it reaches the head.
        assign bank_rsp[b].ready = up_rsp.ready && !q_empty &&
                                   (head_bank == mem_txn_pkg::bank_id_t'(b));
    end

    assign up_req.ready = can_issue && bank_ready[req_bank];

    // --------------------
    // in-order merge
    // --------------------

    assign up_rsp.valid = !q_empty && bank_vld[head_bank];
    assign up_rsp.rdata = bank_rdata[head_bank];   // head bank only.

    assign push = up_req.valid && up_req.ready && is_read;
    assign pop  = up_rsp.valid && up_rsp.ready;

    always_ff @(posedge clk_i) begin
        if (push) begin
            order_q[wr_ptr] <= req_bank;           // remember the target bank.
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;           // wraps at the queue depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or neither.
            endcase
        end
    end

endmodule

// ==== hw/mem_bank.sv ====
module mem_bank #(
    parameter int READ_LATENCY = 9,                // stages from accept to response.
    parameter int BANK_LANES   = 256               // lanes held by this bank.
) (
    input logic       clk_i,
    input logic       rst_i,
    mem_req_if.slave  req,
    mem_rsp_if.source rsp
);

    // --------------------
    // local geometry
    // --------------------

    localparam int IDX_BITS = (BANK_LANES > 1) ? $clog2(BANK_LANES) : 1;
    localparam int IDX_LSB  = mem_geom_pkg::BANK_SEL_BIT + 1; // bank bit not stored.

    // --------------------
    // storage and pipeline
    // --------------------

    mem_geom_pkg::lane_t lanes [BANK_LANES];       // lane array.

    logic                stage_vld  [READ_LATENCY]; // read tag per stage.
    mem_geom_pkg::lane_t stage_data [READ_LATENCY]; // lane carried per stage.

    logic                advance;                  // pipeline moves this cycle.
    logic                req_fire;                 // request accepted.
    logic                rd_fire;                  // read accepted.
    logic                wr_fire;                  // write accepted.
    logic [IDX_BITS-1:0] lane_idx;                 // storage row.

    // mask keeps a one-lane bank on row 0.
    assign lane_idx = req.addr[IDX_LSB +: IDX_BITS] & IDX_BITS'(BANK_LANES - 1);

    // freeze only while the last stage holds data nobody takes.
    assign advance  = !stage_vld[READ_LATENCY-1] || rsp.ready;
    assign req.ready = advance;                    // writes wait too.

    assign req_fire = req.valid && advance;
    assign rd_fire  = req_fire && (req.op == mem_txn_pkg::MEM_OP_READ);
    assign wr_fire  = req_fire && (req.op == mem_txn_pkg::MEM_OP_WRITE);

    // lane write at the accepting edge.
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            lanes[lane_idx] <= req.wdata;
        end
    end

    // valid tags, cleared by reset.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < READ_LATENCY; s++) begin
                stage_vld[s] <= 1'b0;
            end
        end else if (advance) begin
            stage_vld[0] <= rd_fire;               // writes leave a bubble.
            for (int s = 1; s < READ_LATENCY; s++) begin
                stage_vld[s] <= stage_vld[s-1];
            end
        end
    end

    // lane payload moves with the tags.
    always_ff @(posedge clk_i) begin
        if (advance) begin
            if (rd_fire) begin
                stage_data[0] <= lanes[lane_idx];  // copy at accept.
            end
            for (int s = 1; s < READ_LATENCY; s++) begin
                stage_data[s] <= stage_data[s-1];
            end
        end
    end

    // --------------------
    // response side
    // --------------------

    assign rsp.valid = stage_vld[READ_LATENCY-1];  // last stage.
    assign rsp.rdata = stage_data[READ_LATENCY-1];

endmodule

// ==== hw/mem_geom_pkg.sv ====
package mem_geom_pkg;

    // --------------------
    // lane geometry
    // --------------------

    localparam int ADDR_BITS  = 32;                // byte address width.
    localparam int LANE_BYTES = 16;                // one refill lane.
    localparam int LANE_BITS  = LANE_BYTES * 8;    // 128 bits per lane.

    // lanes are 16-byte aligned, so the first bit above the offset
    // picks the bank.
    localparam int BANK_SEL_BIT = $clog2(LANE_BYTES); // bit 4.

    // --------------------
    // types
    // --------------------

    typedef logic [ADDR_BITS-1:0] addr_t;          // byte address.

    // byte 0 sits in bits [7:0], byte 15 in bits [127:120].
    typedef logic [LANE_BITS-1:0] lane_t;

endpackage

// ==== hw/mem_lane_ifs.sv ====
// --------------------
// request channel
// --------------------

interface mem_req_if;

    logic                 valid;                   // request offered.
    logic                 ready;                   // request taken.
    mem_txn_pkg::mem_op_e op;                      // read or write.
    mem_geom_pkg::addr_t  addr;                    // lane-aligned byte address.
    mem_geom_pkg::lane_t  wdata;                   // write lane, ignored on reads.

    modport master (
        output valid,
        output op,
        output addr,
        output wdata,
        input  ready
    );

    modport slave (
        input  valid,
        input  op,
        input  addr,
        input  wdata,
        output ready
    );

endinterface

// --------------------
// response channel
// --------------------

interface mem_rsp_if;

    logic                valid;                    // read data offered.
    logic                ready;                    // read data taken.
    mem_geom_pkg::lane_t rdata;                    // returned lane.

    modport source (
        output valid,
        output rdata,
        input  ready
    );

    modport sink (
        input  valid,
        input  rdata,
        output ready
    );

endinterface

// ==== hw/mem_txn_pkg.sv ====
package mem_txn_pkg;

    // --------------------
    // transaction types
    // --------------------

    // only whole-lane accesses here.
    typedef enum logic [0:0] {
        MEM_OP_READ  = 1'b0,                       // lane read, one response.
        MEM_OP_WRITE = 1'b1                        // lane write, no response.
    } mem_op_e;

    localparam int NUM_BANKS = 2;                  // banks behind the controller.

    // index of a bank, kept in the order queue.
    typedef logic [$clog2(NUM_BANKS)-1:0] bank_id_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lane memory testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vbanked_lane_mem_tb

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module banked_lane_mem_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sources.f ====
hw/mem_geom_pkg.sv
hw/mem_txn_pkg.sv
hw/mem_lane_ifs.sv
hw/mem_bank.sv
hw/lane_order_ctrl.sv
hw/banked_lane_mem.sv
verif/banked_lane_mem_asserts.sv
verif/banked_lane_mem_tb.sv

// ==== verif/banked_lane_mem_asserts.sv ====
module banked_lane_mem_asserts (
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 req_valid_i,
    input logic                 req_ready_o,
    input mem_txn_pkg::mem_op_e req_op_i,
    input mem_geom_pkg::addr_t  req_addr_i,
    input mem_geom_pkg::lane_t  req_wdata_i,
    input logic                 rsp_valid_o,
    input logic                 rsp_ready_i,
    input mem_geom_pkg::lane_t  rsp_rdata_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned pending;                                 // reads accepted, not answered.
    logic        rd_fire;
    logic        rsp_fire;

    assign rd_fire  = req_valid_i && req_ready_o && (req_op_i == mem_txn_pkg::MEM_OP_READ);
    assign rsp_fire = rsp_valid_o && rsp_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending <= 0;
        end else begin
            pending <= pending + 32'(rd_fire) - 32'(rsp_fire);
        end
    end

    // --------------------
    // handshake rules
    // --------------------

    a_req_hold : assert property (@(posedge clk_i) disable iff (rst_i)
        req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_op_i) &&
                                        $stable(req_addr_i) && $stable(req_wdata_i))
        else $error("request changed or dropped while stalled");

    a_rsp_hold : assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o))
        else $error("response changed or dropped while stalled");

    a_rst_quiet : assert property (@(posedge clk_i) rst_i |=> !rsp_valid_o)
        else $error("response valid during reset");

    a_no_orphan : assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_fire |-> pending != 0)
        else $error("response with no outstanding read");

endmodule

bind banked_lane_mem banked_lane_mem_asserts u_asserts (.*);

// ==== verif/banked_lane_mem_tb.sv ====
module banked_lane_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int READ_LATENCY = 9;
    localparam int BANK_LANES   = 256;
    localparam int ORDER_DEPTH  = 8;
    localparam int LIMIT_HOLD   = 20;                     // rsp_ready low in the limit test.
    localparam logic [31:0] LCG_SEED = 32'd47485;
    localparam mem_txn_pkg::mem_op_e OP_RD = mem_txn_pkg::MEM_OP_READ;
    localparam mem_txn_pkg::mem_op_e OP_WR = mem_txn_pkg::MEM_OP_WRITE;

    typedef struct {
        string                name;                       // test group.
        mem_txn_pkg::mem_op_e op;
        mem_geom_pkg::addr_t  addr;
        int                   seed;                       // write data seed.
        int                   stall;                      // rsp_ready low cycles from issue.
    } row_t;

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    logic                 req_valid_i;
    logic                 req_ready_o;
    mem_txn_pkg::mem_op_e req_op_i;
    mem_geom_pkg::addr_t  req_addr_i;
    mem_geom_pkg::lane_t  req_wdata_i;
    logic                 rsp_valid_o;
    logic                 rsp_ready_i;
    mem_geom_pkg::lane_t  rsp_rdata_o;

    row_t                 rows [$];
    mem_geom_pkg::lane_t  ref_mem [mem_geom_pkg::addr_t]; // reference lanes by address.
    mem_geom_pkg::lane_t  exp_q [$];                      // expected lanes, issue order.
    int                   acc_q [$];                      // accept edge per read.
    bit                   lat_q [$];                      // read issued with nothing in flight.
    string                name_q [$];
    string                cur_name;
    mem_geom_pkg::lane_t  held_lane;                      // response seen under stall.
    bit                   held = 1'b0;
    int                   stall_left = 0;
    int                   last_stall_edge = -1;
    int                   cyc = 0;                        // rising edges so far.
    int                   cycle_limit = 1000000;
    int                   max_stall;
    logic                 first_rdy;

    banked_lane_mem #(
        .READ_LATENCY (READ_LATENCY),
        .BANK_LANES   (BANK_LANES),
        .ORDER_DEPTH  (ORDER_DEPTH)
    ) dut (.*);

    always #4 clk_i = ~clk_i;                             // 8 ns period.

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc > cycle_limit) begin
            $display("ERROR: timeout, the test did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // --------------------
    // helpers
    // --------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // four lcg words, mixed with the seed and every address bit.
    function automatic mem_geom_pkg::lane_t lane_from_seed(input int seed,
                                                           input mem_geom_pkg::addr_t addr);
        logic [31:0]         s;
        mem_geom_pkg::lane_t lane;
        s = LCG_SEED ^ addr ^ (32'(seed) << 16);
        for (int w = 0; w < 4; w++) begin
            s = lcg_next(s);
            lane[w*32 +: 32] = s;                         // word 0 in the low bits.
        end
        return lane;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_lane(input string name, input mem_geom_pkg::lane_t exp,
                              input mem_geom_pkg::lane_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: expected %0d cycles, actual %0d cycles",
                                    name, exp, act));
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic add_row(input string name, input mem_txn_pkg::mem_op_e op,
                           input mem_geom_pkg::addr_t addr, input int seed, input int stall);
        row_t r;
        r = '{name, op, addr, seed, stall};
        rows.push_back(r);
    endtask

    task automatic take_response();
        string name;
        int    acc;
        bit    lat;
        if (exp_q.size() == 0) begin
            stop_on_error("a response arrived while no read was outstanding");
        end else begin
            name = name_q.pop_front();
            acc  = acc_q.pop_front();
            lat  = lat_q.pop_front();
            check_lane(name, exp_q.pop_front(), rsp_rdata_o);
            if (lat && last_stall_edge < acc) begin       // untouched by back-pressure.
                check_latency(name, READ_LATENCY, cyc + 1 - acc);
            end
        end
    endtask

    task automatic record_accept();
        if (req_op_i == OP_WR) begin
            ref_mem[req_addr_i] = req_wdata_i;            // seen by later reads.
        end else if (!ref_mem.exists(req_addr_i)) begin
            stop_on_error($sformatf("the table reads address %h before writing it", req_addr_i));
        end else begin
            lat_q.push_back(exp_q.size() == 0);
            exp_q.push_back(ref_mem[req_addr_i]);
            acc_q.push_back(cyc + 1);
            name_q.push_back(cur_name);
        end
    endtask

    // look mid low phase, then move on to the next falling edge.
    task automatic sample_cycle(output bit accepted, output logic rdy);
        #2;
        rdy      = req_ready_o;
        accepted = req_valid_i && req_ready_o;
        if (held) begin
            check_ready("rsp_hold", 1'b1, rsp_valid_o);
            check_lane("rsp_hold", held_lane, rsp_rdata_o);
        end
        held = 1'b0;
        if (rsp_valid_o && rsp_ready_i) begin
            take_response();
        end else if (rsp_valid_o) begin
            held      = 1'b1;                             // must not change next cycle.
            held_lane = rsp_rdata_o;
        end
        if (!rsp_ready_i) begin
            last_stall_edge = cyc + 1;
        end
        if (accepted) begin
            record_accept();
        end
        @(negedge clk_i);
        rsp_ready_i = (stall_left == 0);
        if (stall_left > 0) begin
            stall_left--;
        end
    endtask

    task automatic start_stall(input int n);
        rsp_ready_i = 1'b0;
        stall_left  = n - 1;
    endtask

    task automatic issue_req(input string name, input mem_txn_pkg::mem_op_e op,
                             input mem_geom_pkg::addr_t addr, input int seed,
                             output logic first);
        bit   accepted;
        logic rdy;
        int   waits;
        cur_name    = name;
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_wdata_i = (op == OP_WR) ? lane_from_seed(seed, addr) : '0;
        accepted    = 1'b0;
        waits       = 0;
        while (!accepted) begin
            sample_cycle(accepted, rdy);                  // payload holds until taken.
            if (waits == 0) begin
                first = rdy;
            end
            waits++;
        end
        req_valid_i = 1'b0;
    endtask

    task automatic drain();
        bit   accepted;
        logic rdy;
        req_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            sample_cycle(accepted, rdy);
        end
    endtask

    // --------------------
    // stimulus
    // --------------------

    initial begin
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_op_i    = OP_RD;
        req_addr_i  = '0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b1;

        add_row("write_fill",   OP_WR, 32'h000, 1, 0);
        add_row("write_fill",   OP_WR, 32'h010, 2, 0);
        add_row("write_fill",   OP_WR, 32'h020, 3, 0);
        add_row("write_fill",   OP_WR, 32'h030, 4, 0);
        add_row("latency",      OP_RD, 32'h010, 0, 0);
        add_row("stream",       OP_RD, 32'h000, 0, 0);    // alternating banks.
        add_row("stream",       OP_RD, 32'h010, 0, 0);
        add_row("stream",       OP_RD, 32'h020, 0, 0);
        add_row("stream",       OP_RD, 32'h030, 0, 0);
        add_row("stream",       OP_RD, 32'h000, 0, 0);    // bank 0 run.
        add_row("stream",       OP_RD, 32'h020, 0, 0);
        add_row("backpressure", OP_RD, 32'h000, 0, 0);
        add_row("backpressure", OP_RD, 32'h010, 0, 12);   // spans the first response.
        add_row("backpressure", OP_RD, 32'h020, 0, 0);
        add_row("backpressure", OP_RD, 32'h030, 0, 0);
        add_row("write_read",   OP_WR, 32'h020, 6, 0);
        add_row("write_read",   OP_RD, 32'h020, 0, 0);    // sees the new lane.

        max_stall = LIMIT_HOLD;
        foreach (rows[i]) begin
            if (rows[i].stall > max_stall) begin
                max_stall = rows[i].stall;
            end
        end
        cycle_limit = (rows.size() + ORDER_DEPTH + 1) * (READ_LATENCY + max_stall + 4) + 100;

        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;
        #2;
        check_ready("reset", 1'b0, rsp_valid_o);
        check_ready("reset", 1'b1, req_ready_o);
        @(negedge clk_i);

        for (int i = 0; i < rows.size(); i++) begin
            if (i > 0 && rows[i].name != rows[i-1].name) begin
                drain();                                  // groups start empty.
            end
            if (rows[i].stall > 0) begin
                start_stall(rows[i].stall);
            end
            issue_req(rows[i].name, rows[i].op, rows[i].addr, rows[i].seed, first_rdy);
        end
        drain();

        // queue fills, one more read must wait.
        start_stall(LIMIT_HOLD);
        for (int i = 0; i <= ORDER_DEPTH; i++) begin
            issue_req("limit", OP_RD, mem_geom_pkg::addr_t'((i * 16) % 64), 0, first_rdy);
            check_ready("limit", i < ORDER_DEPTH, first_rdy);
        end
        drain();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
